/* include/lcd_timing_defaults.svh */
`ifndef LCD_TIMING_DEFAULTS_SVH
`define LCD_TIMING_DEFAULTS_SVH

// horizontal, in pixel clocks
`define LCD_H_DISP  32 // visible pixels per line
`define LCD_H_FRONT 2
`define LCD_H_SYNC  3
`define LCD_H_BACK  3

// vertical, in lines
`define LCD_V_DISP  16 // visible lines per frame
`define LCD_V_FRONT 1
`define LCD_V_SYNC  2
`define LCD_V_BACK  1

// tiny panel so a full frame simulates quickly

`endif

/* hw/lcd_pattern_pkg.sv */
`default_nettype none

package lcd_pattern_pkg;

	// ----------------------------------------
	// raster geometry
	localparam int COORD_W = 11; // up to 2047 pixels or lines

	// pattern select as held in REG_CTRL[2:1]
	typedef enum logic [1:0] {
		PAT_VBAR    = 2'd0, // bars across x
		PAT_HBAR    = 2'd1, // bars down y
		PAT_GRAY    = 2'd2, // y ramp on top, x ramp below
		PAT_PRODUCT = 2'd3  // x*y pattern
	} pattern_mode_e;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// ----------------------------------------
	// bar colours, left to right / top to bottom
	localparam rgb_t COL_RED     = 24'hFF0000;
	localparam rgb_t COL_GREEN   = 24'h00FF00;
	localparam rgb_t COL_BLUE    = 24'h0000FF;
	localparam rgb_t COL_WHITE   = 24'hFFFFFF;
	localparam rgb_t COL_BLACK   = 24'h000000; // also the blanking colour
	localparam rgb_t COL_YELLOW  = 24'hFFFF00;
	localparam rgb_t COL_MAGENTA = 24'hFF00FF;
	localparam rgb_t COL_CYAN    = 24'h00FFFF;

	localparam rgb_t bar_palette [8] = '{
		COL_RED, COL_GREEN, COL_BLUE, COL_WHITE,
		COL_BLACK, COL_YELLOW, COL_MAGENTA, COL_CYAN
	};

	// timing generator output, one beat per clock
	typedef struct packed {
		logic               hs;
		logic               vs;
		logic               de;
		logic [COORD_W-1:0] x;           // 0 outside the display area
		logic [COORD_W-1:0] y;
		logic               frame_start; // first clock of a frame
	} raster_pos_t;

	typedef struct packed {
		logic hs;
		logic vs;
		logic de;
		rgb_t rgb;
	} lcd_pixel_t;

	// ----------------------------------------
	// register map and bus responses
	localparam logic [3:0] REG_CTRL    = 4'h0; // [0] enable, [2:1] mode
	localparam logic [3:0] REG_FRAMES  = 4'h4; // read only frame count
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

/* hw/lcd_raster_timing.sv */
`timescale 1ns/10ps
`default_nettype none

module lcd_raster_timing
	import lcd_pattern_pkg::*;
#(
	parameter int H_DISP  = 32,
	parameter int H_FRONT = 2,
	parameter int H_SYNC  = 3,
	parameter int H_BACK  = 3,
	parameter int V_DISP  = 16,
	parameter int V_FRONT = 1,
	parameter int V_SYNC  = 2,
	parameter int V_BACK  = 1
)
(
	input  logic        clk,
	input  logic        rst_n,
	output raster_pos_t pos
);

	// ----------------------------------------
	// line and frame geometry
	localparam int H_TOTAL  = H_DISP + H_FRONT + H_SYNC + H_BACK; // clocks per line
	localparam int V_TOTAL  = V_DISP + V_FRONT + V_SYNC + V_BACK; // lines per frame
	localparam int H_CNT_W  = $clog2(H_TOTAL);
	localparam int V_CNT_W  = $clog2(V_TOTAL);
	localparam int HS_BEGIN = H_DISP + H_FRONT;   // sync right after front porch
	localparam int HS_END   = HS_BEGIN + H_SYNC;
	localparam int VS_BEGIN = V_DISP + V_FRONT;
	localparam int VS_END   = VS_BEGIN + V_SYNC;

	logic [H_CNT_W-1:0] h_count; // pixel within line
	logic [V_CNT_W-1:0] v_count; // line within frame
	logic               line_end;
	logic               frame_end;
	logic               h_active;
	logic               v_active;

	assign line_end  = (h_count == H_CNT_W'(H_TOTAL - 1));
	assign frame_end = (v_count == V_CNT_W'(V_TOTAL - 1));

	// ----------------------------------------
	// counters, free running
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			h_count <= '0;
			v_count <= '0;
		end
		else if (line_end)
		begin
			h_count <= '0;
			if (frame_end)
				v_count <= '0; // wrap to top of next frame
			else
				v_count <= v_count + 1'b1;
		end
		else
		begin
			h_count <= h_count + 1'b1;
		end
	end

	// ----------------------------------------
	// window decode
	assign h_active = (h_count < H_DISP);
	assign v_active = (v_count < V_DISP);

	always_comb
	begin
		pos.de = h_active & v_active;
		pos.hs = (h_count >= HS_BEGIN) && (h_count < HS_END);
		pos.vs = (v_count >= VS_BEGIN) && (v_count < VS_END); // whole lines

		// coordinates only mean something inside the picture
		pos.x = pos.de ? COORD_W'(h_count) : '0;
		pos.y = pos.de ? COORD_W'(v_count) : '0;

		// one clock at the top-left corner
		pos.frame_start = (h_count == '0) && (v_count == '0);
	end

endmodule

`default_nettype wire

/* hw/lcd_test_pattern.sv */
`timescale 1ns/10ps
`default_nettype none

module lcd_test_pattern
	import lcd_pattern_pkg::*;
#(
	parameter int H_DISP = 32,
	parameter int V_DISP = 16
)
(
	input  logic          clk,
	input  logic          rst_n,
	input  raster_pos_t   pos,
	input  pattern_mode_e mode,
	input  logic          enable,
	output lcd_pixel_t    out_pixel
);

	// ----------------------------------------
	// bar and ramp geometry
	localparam int H_BAR   = H_DISP / 8; // pixels per vertical bar
	localparam int V_BAR   = V_DISP / 8; // lines per horizontal bar
	localparam int V_SPLIT = V_DISP / 2; // gray ramp switches from y to x here

	logic [2:0]           vbar_idx;
	logic [2:0]           hbar_idx;
	logic [7:0]           gray_lvl;
	logic [2*COORD_W-1:0] prod;    // 22 bits, fits the 24 bit pixel
	rgb_t                 pat_rgb; // colour before blanking

	assign vbar_idx = 3'(pos.x / COORD_W'(H_BAR));
	assign hbar_idx = 3'(pos.y / COORD_W'(V_BAR));

	// top half ramps with y, bottom half with x
	assign gray_lvl = (pos.y < COORD_W'(V_SPLIT)) ? pos.y[7:0] : pos.x[7:0];

	assign prod = pos.x * pos.y;

	// ----------------------------------------
	// colour select
	always_comb
	begin
		case (mode)
			PAT_VBAR:
				pat_rgb = bar_palette[vbar_idx];
			PAT_HBAR:
				pat_rgb = bar_palette[hbar_idx];
			PAT_GRAY:
				pat_rgb = {gray_lvl, gray_lvl, gray_lvl}; // same level in r, g, b
			PAT_PRODUCT:
				pat_rgb = rgb_t'(24'(prod)); // zero extended
			default:
				pat_rgb = COL_BLACK;
		endcase
	end

	// ----------------------------------------
	// output stage, one clock of latency
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_pixel <= '0;
		end
		else
		begin
			// syncs ride along with the colour
			out_pixel.hs <= pos.hs;
			out_pixel.vs <= pos.vs;
			out_pixel.de <= pos.de;

			// blank outside picture or when disabled
			if (pos.de && enable)
				out_pixel.rgb <= pat_rgb;
			else
				out_pixel.rgb <= COL_BLACK;
		end
	end

endmodule

`default_nettype wire

/* hw/pattern_ctrl_axil.sv */
`timescale 1ns/10ps
`default_nettype none

module pattern_ctrl_axil
	import lcd_pattern_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	input  logic [3:0]    awaddr,  // write address
	input  logic          awvalid,
	output logic          awready,
	input  logic [31:0]   wdata,   // write data
	input  logic [3:0]    wstrb,
	input  logic          wvalid,
	output logic          wready,
	output logic [1:0]    bresp,   // write response
	output logic          bvalid,
	input  logic          bready,
	input  logic [3:0]    araddr,  // read address
	input  logic          arvalid,
	output logic          arready,
	output logic [31:0]   rdata,   // read data
	output logic [1:0]    rresp,
	output logic          rvalid,
	input  logic          rready,
	input  logic          frame_start,
	output pattern_mode_e active_mode,
	output logic          active_enable
);

	typedef struct packed {
		pattern_mode_e mode;   // bits 2:1
		logic          enable; // bit 0
	} ctrl_reg_t;

	ctrl_reg_t   ctrl_q;    // host view
	ctrl_reg_t   shadow_q;  // pixel path view, frame aligned
	logic [15:0] frame_cnt; // wraps

	logic        aw_held;   // aw taken, waiting for w
	logic        w_held;    // w taken, waiting for aw
	logic [3:0]  aw_addr_q;
	logic [31:0] w_data_q;
	logic [3:0]  w_strb_q;

	logic        resp_busy;
	logic        aw_hs;
	logic        w_hs;
	logic        ar_hs;
	logic        wr_fire;
	logic [3:0]  wr_addr;
	logic [31:0] wr_data;
	logic [3:0]  wr_strb;
	logic [31:0] rd_mux;
	logic [1:0]  rd_resp;

	// ----------------------------------------
	// handshakes, all held off while a response waits
	assign resp_busy = bvalid | rvalid;
	assign awready   = ~aw_held & ~resp_busy;
	assign wready    = ~w_held & ~resp_busy;
	assign arready   = ~resp_busy;

	assign aw_hs = awvalid & awready;
	assign w_hs  = wvalid & wready;
	assign ar_hs = arvalid & arready;

	// both halves in hand, now or from an earlier edge
	assign wr_fire = (aw_held | aw_hs) & (w_held | w_hs);
	assign wr_addr = aw_held ? aw_addr_q : awaddr;
	assign wr_data = w_held ? w_data_q : wdata;
	assign wr_strb = w_held ? w_strb_q : wstrb;

	always_ff @(posedge clk)
	begin
		if (aw_hs)
			aw_addr_q <= awaddr;
		if (w_hs)
		begin
			w_data_q <= wdata;
			w_strb_q <= wstrb;
		end
	end

	// ----------------------------------------
	// write channel
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			aw_held <= 1'b0;
			w_held  <= 1'b0;
			bvalid  <= 1'b0;
			bresp   <= RESP_OKAY;
		end
		else if (wr_fire)
		begin
			aw_held <= 1'b0;
			w_held  <= 1'b0;
			bvalid  <= 1'b1;
			if (wr_addr == REG_CTRL || wr_addr == REG_FRAMES)
				bresp <= RESP_OKAY; // frame count write is ignored
			else
				bresp <= RESP_SLVERR;
		end
		else
		begin
			if (aw_hs)
				aw_held <= 1'b1;
			if (w_hs)
				w_held <= 1'b1;
			if (bvalid && bready)
				bvalid <= 1'b0;
		end
	end

	// ----------------------------------------
	// control register, shadow, frame count
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ctrl_q    <= '{mode: PAT_VBAR, enable: 1'b0};
			shadow_q  <= '{mode: PAT_VBAR, enable: 1'b0};
			frame_cnt <= '0;
		end
		else
		begin
			if (wr_fire && wr_addr == REG_CTRL && wr_strb[0])
				ctrl_q <= ctrl_reg_t'(wr_data[2:0]);
			if (frame_start)
			begin
				shadow_q  <= ctrl_q; // new mode only from a frame boundary
				frame_cnt <= frame_cnt + 16'd1;
			end
		end
	end

	// first pixel of a frame already sees the value the shadow takes
	assign active_mode   = frame_start ? ctrl_q.mode : shadow_q.mode;
	assign active_enable = frame_start ? ctrl_q.enable : shadow_q.enable;

	// ----------------------------------------
	// read channel
	always_comb
	begin
		rd_mux  = '0;
		rd_resp = RESP_OKAY;
		case (araddr)
			REG_CTRL:
				rd_mux = {29'd0, ctrl_q};
			REG_FRAMES:
				rd_mux = {16'd0, frame_cnt};
			default:
				rd_resp = RESP_SLVERR; // unmapped reads return 0
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rvalid <= 1'b0;
			rresp  <= RESP_OKAY;
			rdata  <= '0;
		end
		else if (ar_hs)
		begin
			rvalid <= 1'b1;
			rresp  <= rd_resp;
			rdata  <= rd_mux;
		end
		else if (rvalid && rready)
		begin
			rvalid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hw/lcd_pattern_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lcd_timing_defaults.svh"

module lcd_pattern_top
	import lcd_pattern_pkg::*;
#(
	parameter int H_DISP  = `LCD_H_DISP,
	parameter int H_FRONT = `LCD_H_FRONT,
	parameter int H_SYNC  = `LCD_H_SYNC,
	parameter int H_BACK  = `LCD_H_BACK,
	parameter int V_DISP  = `LCD_V_DISP,
	parameter int V_FRONT = `LCD_V_FRONT,
	parameter int V_SYNC  = `LCD_V_SYNC,
	parameter int V_BACK  = `LCD_V_BACK
)
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic [3:0]  awaddr,  // host bus, AXI4-Lite
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [3:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	output lcd_pixel_t  out_pixel // display side, one pixel per clock
);

	raster_pos_t   pos;           // scan position
	pattern_mode_e active_mode;   // frame aligned mode
	logic          active_enable;

	// ----------------------------------------
	// raster scan
	lcd_raster_timing #(
		.H_DISP(H_DISP), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_DISP(V_DISP), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) u_timing (
		.clk(clk), .rst_n(rst_n), .pos(pos)
	);

	// pixel colour
	lcd_test_pattern #(
		.H_DISP(H_DISP), .V_DISP(V_DISP)
	) u_pattern (
		.clk(clk), .rst_n(rst_n), .pos(pos),
		.mode(active_mode), .enable(active_enable), .out_pixel(out_pixel)
	);

	// host registers
	pattern_ctrl_axil u_ctrl (
		.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.frame_start(pos.frame_start), // shadow load and frame count
		.active_mode(active_mode), .active_enable(active_enable)
	);

endmodule

`default_nettype wire

/* bench/tb_lcd_pattern.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lcd_timing_defaults.svh"

module tb_lcd_pattern
	import lcd_pattern_pkg::*;
();

	localparam int H_DISP    = `LCD_H_DISP;
	localparam int V_DISP    = `LCD_V_DISP;
	localparam int H_TOTAL   = `LCD_H_DISP + `LCD_H_FRONT + `LCD_H_SYNC + `LCD_H_BACK;
	localparam int V_TOTAL   = `LCD_V_DISP + `LCD_V_FRONT + `LCD_V_SYNC + `LCD_V_BACK;
	localparam int FRAME_LEN = H_TOTAL * V_TOTAL; // clocks per frame
	localparam int HS_FIRST  = `LCD_H_DISP + `LCD_H_FRONT; // hsync follows the front porch
	localparam int HS_END    = HS_FIRST + `LCD_H_SYNC;
	localparam int VS_FIRST  = `LCD_V_DISP + `LCD_V_FRONT; // in lines
	localparam int VS_END    = VS_FIRST + `LCD_V_SYNC;

	logic        clk;
	logic        rst_n;
	logic [3:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [3:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	lcd_pixel_t  out_pixel;

	logic [1:0]  exp_mode;    // model view of the last written mode
	logic        exp_en;
	logic [15:0] last_frames; // previous REG_FRAMES read

	// stim file contents, one entry per command
	logic [7:0]  op_q [$];
	logic [31:0] addr_q [$];
	logic [31:0] data_q [$];
	logic [31:0] resp_q [$];

	lcd_pattern_top u_dut (
		.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.out_pixel(out_pixel)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	// ----------------------------------------
	// reference pixel model
	function automatic logic [23:0] bar_colour(input int idx);
		case (idx)
			0: return 24'hFF0000; // red
			1: return 24'h00FF00;
			2: return 24'h0000FF;
			3: return 24'hFFFFFF;
			4: return 24'h000000;
			5: return 24'hFFFF00; // yellow
			6: return 24'hFF00FF;
			default: return 24'h00FFFF;
		endcase
	endfunction

	function automatic logic [23:0] expected_rgb(input int x, input int y);
		logic [7:0] lvl;
		if (!exp_en)
			return 24'h0;
		lvl = (y < V_DISP / 2) ? 8'(y) : 8'(x); // top half ramps with y
		case (exp_mode)
			2'd0: return bar_colour(x / (H_DISP / 8));
			2'd1: return bar_colour(y / (V_DISP / 8));
			2'd2: return {lvl, lvl, lvl};
			default: return 24'(x * y);
		endcase
	endfunction

	// ----------------------------------------
	// AXI4-Lite master, random response stalls
	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
		input int aw_delay, input int w_delay, output logic [1:0] resp);
		logic aw_left;
		logic w_left;
		logic aw_take;
		logic w_take;
		int   cyc;
		int   stall;
		awaddr  = addr;
		wdata   = data;
		wstrb   = 4'hF;
		aw_left = 1'b1;
		w_left  = 1'b1;
		cyc     = 0;
		while (aw_left || w_left)
		begin
			awvalid = aw_left && (cyc >= aw_delay); // one channel may lag the other
			wvalid  = w_left && (cyc >= w_delay);
			aw_take = awvalid & awready; // readies are registered, steady all cycle
			w_take  = wvalid & wready;
			@(posedge clk);
			#1;
			cyc++;
			if (aw_take)
				aw_left = 1'b0;
			if (w_take)
				w_left = 1'b0;
		end
		awvalid = 1'b0;
		wvalid  = 1'b0;
		while (!bvalid)
		begin
			@(posedge clk);
			#1;
		end
		stall = $urandom_range(4, 0);
		repeat (stall)
		begin
			check_value("awready while bvalid", awready, 0); // back-pressure
			check_value("wready while bvalid", wready, 0);
			check_value("arready while bvalid", arready, 0);
			@(posedge clk);
			#1;
		end
		resp   = bresp;
		bready = 1'b1;
		@(posedge clk);
		#1;
		bready = 1'b0;
		check_value("bvalid after handshake", bvalid, 0);
	endtask

	task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		logic taken;
		int   stall;
		araddr  = addr;
		arvalid = 1'b1;
		taken   = 1'b0;
		while (!taken)
		begin
			taken = arready;
			@(posedge clk);
			#1;
		end
		arvalid = 1'b0;
		while (!rvalid)
		begin
			@(posedge clk);
			#1;
		end
		stall = $urandom_range(4, 0);
		repeat (stall)
		begin
			check_value("arready while rvalid", arready, 0);
			check_value("awready while rvalid", awready, 0);
			@(posedge clk);
			#1;
		end
		data   = rdata; // payload held while rvalid waits
		resp   = rresp;
		rready = 1'b1;
		@(posedge clk);
		#1;
		rready = 1'b0;
		check_value("rvalid after handshake", rvalid, 0);
	endtask

	// ----------------------------------------
	// frame checker, x and y rebuilt from de
	task automatic check_frames(input int n);
		int   x;
		int   y;
		int   h; // scan position counted from the vsync edge
		int   v;
		logic was_de;
		logic prev_vs;
		do
		begin
			prev_vs = out_pixel.vs;
			@(posedge clk);
			#1;
		end while (!(out_pixel.vs && !prev_vs)); // sync to a fresh vsync
		h = 0; // vsync rises with the first clock of its line
		v = VS_FIRST;
		repeat (n)
		begin
			x      = 0;
			y      = 0;
			was_de = 1'b0;
			do
			begin
				prev_vs = out_pixel.vs;
				@(posedge clk);
				#1;
				if (h == H_TOTAL - 1)
				begin
					h = 0;
					v = (v == V_TOTAL - 1) ? 0 : v + 1;
				end
				else
				begin
					h++;
				end
				check_value("out_pixel.hs", out_pixel.hs, h >= HS_FIRST && h < HS_END);
				check_value("out_pixel.vs", out_pixel.vs, v >= VS_FIRST && v < VS_END);
				check_value("out_pixel.de", out_pixel.de, h < H_DISP && v < V_DISP);
				if (out_pixel.de)
				begin
					check_value("out_pixel.rgb", out_pixel.rgb, expected_rgb(x, y));
					x++;
					was_de = 1'b1;
				end
				else
				begin
					check_value("out_pixel.rgb in blanking", out_pixel.rgb, 0);
					if (was_de)
					begin
						check_value("de cycles per line", x, H_DISP); // end of line
						x = 0;
						y++;
					end
					was_de = 1'b0;
				end
			end while (!(out_pixel.vs && !prev_vs));
			check_value("lines with de", y, V_DISP);
		end
	endtask

	// ----------------------------------------
	// stim file, reset, command loop
	initial
	begin
		int          fd;
		int          c;
		int          limit;
		int          n_wr;
		logic [7:0]  op;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] r;
		logic [31:0] got_d;
		logic [1:0]  got_r;
		logic [15:0] rise;
		rst_n   = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		exp_mode    = 2'd0; // reset state, bars but disabled
		exp_en      = 1'b0;
		last_frames = '0;
		n_wr        = 0;
		c     = $urandom(7);
		limit = 5 + 50; // reset and slack
		fd = $fopen("bench/lcd_pattern_stim.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the stimulus file bench/lcd_pattern_stim.txt");
			$display("Checks failed");
			$fatal(1);
		end
		while ($fscanf(fd, " %c", op) == 1)
		begin
			if (op == "#")
			begin
				c = $fgetc(fd); // skip comment line
				while (c != "\n" && c != -1)
					c = $fgetc(fd);
			end
			else if (op == "W" || op == "R")
			begin
				c = $fscanf(fd, "%h %h %h", a, d, r);
				op_q.push_back(op);
				addr_q.push_back(a);
				data_q.push_back(d);
				resp_q.push_back(r);
				limit += 200;
			end
			else if (op == "F")
			begin
				c = $fscanf(fd, "%d", a);
				op_q.push_back(op);
				addr_q.push_back(a);
				data_q.push_back(0);
				resp_q.push_back(0);
				limit += (a + 1) * FRAME_LEN; // one extra frame for the vsync wait
			end
			else
			begin
				$display("unknown command '%c' in the stimulus file", op);
				$display("Checks failed");
				$fatal(1);
			end
		end
		$fclose(fd);

		fork
			begin
				#(limit * 4);
				$display("timeout: run did not finish within %0d cycles", limit);
				$display("Checks failed");
				$fatal(1);
			end
		join_none

		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;

		foreach (op_q[i])
		begin
			if (op_q[i] == "W")
			begin
				// aw and w together, w late, aw late in turn
				write_reg(addr_q[i][3:0], data_q[i], (n_wr % 3 == 2) ? 2 : 0,
					(n_wr % 3 == 1) ? 2 : 0, got_r);
				n_wr++;
				check_value("bresp", got_r, resp_q[i]);
				if (addr_q[i] == 0)
					{exp_mode, exp_en} = data_q[i][2:0];
			end
			else if (op_q[i] == "R")
			begin
				read_reg(addr_q[i][3:0], got_d, got_r);
				check_value("rresp", got_r, resp_q[i]);
				if (addr_q[i] == 4)
				begin
					rise = got_d[15:0] - last_frames; // count wraps at 16 bits
					check_value("REG_FRAMES increase", rise, data_q[i]);
					last_frames = got_d[15:0];
				end
				else
				begin
					check_value("rdata", got_d, data_q[i]);
				end
			end
			else
			begin
				check_frames(addr_q[i]);
			end
		end

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/lcd_pattern_stim.txt */
# op addr data resp, hex fields; F takes a decimal frame count
# W writes data and expects resp, R expects data and resp
# for R 4 the data column is the count increase since the last R 4
# F n waits for vsync then checks n frames, so it spans n+1 frame starts
# reset state, pattern disabled
R 0 0 0
F 1
R 4 2 0
# vertical bars
W 0 1 0
R 0 1 0
F 1
# horizontal bars
W 0 3 0
R 0 3 0
F 1
# gray ramp
W 0 5 0
R 0 5 0
F 1
# coordinate product
W 0 7 0
R 0 7 0
F 1
R 4 8 0
F 2
R 4 3 0
# unmapped address, control register untouched
W 8 1 2
R 8 0 2
R 0 7 0

/* build.f */
+incdir+include
hw/lcd_pattern_pkg.sv
hw/lcd_raster_timing.sv
hw/lcd_test_pattern.sv
hw/pattern_ctrl_axil.sv
hw/lcd_pattern_top.sv
bench/tb_lcd_pattern.sv
